/* sources.f */
+incdir+common
common/psx_pkg.sv
common/mem_wr_if.sv
hw/rom_download/rom_download_packer.sv
hw/backup_ram/backup_buffer_ram.sv
hw/backup_ram/backup_flush.sv
hw/mem_write_arbiter.sv
hw/psx_mem_loader_top.sv
sim/tb_clock_gen.sv
sim/tb_psx_mem_loader.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := tb_psx_mem_loader
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_psx_mem_loader.sv */
// testbench for the psx memory loader covering downloads, backup flush and the shared write port
`include "psx_macros.svh"

module tb_psx_mem_loader;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ROWS = 6;
	localparam int K_RESET = 0;
	localparam int K_BIOS = 1;
	localparam int K_EXE = 2;
	localparam int K_BACKP = 3;
	localparam int K_FLUSH = 4;
	localparam int K_OVERLAP = 5;
	// worst case clocks per unit of row length
	localparam int STALL_FACTOR = 24;

	logic clk_1x;
	logic rst_n;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [`PSX_ADDR_W-1:0] ioctl_addr;
	logic [`PSX_HALF_W-1:0] ioctl_dout;
	logic ioctl_wait;
	logic load_exe;
	logic [`PSX_BKBUF_AW-1:0] sd_buff_addr;
	logic [`PSX_HALF_W-1:0] sd_buff_dout;
	logic sd_buff_wr;
	logic [`PSX_HALF_W-1:0] sd_buff_din;
	logic flush_start;
	logic [7:0] flush_sector;
	logic flush_busy;
	logic flush_done;
	logic mem_wr_valid;
	logic mem_wr_ready;
	logic [`PSX_ADDR_W-1:0] mem_wr_addr;
	logic [`PSX_DATA_W-1:0] mem_wr_data;
	logic [`PSX_BE_W-1:0] mem_wr_be;

	// ========================================
	// test table and bookkeeping
	// ========================================
	string row_name [N_ROWS];
	int row_kind [N_ROWS];
	int row_len [N_ROWS];
	int row_sector [N_ROWS];

	integer seed = 67764;
	logic ready_hold;
	logic dl_finished;
	// transfers seen by the memory model keyed by byte address
	logic [31:0] log_data [int];
	logic [3:0] log_be [int];
	int log_hits [int];
	int xfer_count;
	int load_exe_count;
	int load_exe_in_dl;
	int done_count;
	// expected stimulus
	logic [15:0] dl_half [$];
	logic [15:0] buf_model [`PSX_BKBUF_DEPTH];
	string cur_test;
	int test_errors;
	int failed_tests;
	int total_errors;
	int cycle_count;
	int timeout_limit = 1000000;

	tb_clock_gen u_clk (.clk_1x(clk_1x), .rst_n(rst_n));

	psx_mem_loader_top dut (.*);

	// ========================================
	// memory model
	// ========================================
	// ready driven on the falling edge and the transfer logged just after
	always @(negedge clk_1x) begin
		logic [31:0] r;
		int key;
		r = $random(seed);
		mem_wr_ready = ready_hold ? 1'b0 : r[0];
		#1;
		if (rst_n && mem_wr_valid && mem_wr_ready) begin
			key = int'(mem_wr_addr);
			log_hits[key] = log_hits.exists(key) ? log_hits[key] + 1 : 1;
			log_data[key] = mem_wr_data;
			log_be[key] = mem_wr_be;
			xfer_count++;
		end
		if (rst_n && load_exe) begin
			load_exe_count++;
			if (ioctl_download) load_exe_in_dl++;
		end
		if (rst_n && flush_done) done_count++;
	end

	// run limit from the table lengths
	always @(posedge clk_1x) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("Verification failed");
			$finish;
		end
	end

	// ========================================
	// helpers
	// ========================================
	task automatic set_row(input int n, input string name, input int kind, input int len,
		input int sector);
		row_name[n] = name;
		row_kind[n] = kind;
		row_len[n] = len;
		row_sector[n] = sector;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("ERR %s %s: expected %h actual %h", cur_test, what, expv, actv);
		test_errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic clear_log();
		log_data.delete();
		log_be.delete();
		log_hits.delete();
		xfer_count = 0;
		load_exe_count = 0;
		load_exe_in_dl = 0;
		done_count = 0;
	endtask

	// host never writes while ioctl_wait is up
	task automatic run_download(input logic [7:0] index, input int nhalf);
		logic [31:0] r;
		dl_half.delete();
		dl_finished = 1'b0;
		@(negedge clk_1x);
		ioctl_download = 1'b1;
		ioctl_index = index;
		// target is registered so one clock passes before the first write
		@(negedge clk_1x);
		for (int j = 0; j < nhalf; j++) begin
			while (ioctl_wait) @(negedge clk_1x);
			r = $random(seed);
			dl_half.push_back(r[15:0]);
			ioctl_wr = 1'b1;
			ioctl_addr = `PSX_ADDR_W'(2 * j);
			ioctl_dout = r[15:0];
			@(negedge clk_1x);
			ioctl_wr = 1'b0;
		end
		while (ioctl_wait) @(negedge clk_1x);
		ioctl_download = 1'b0;
		dl_finished = 1'b1;
	endtask

	// three stretches of ready low, each held over a pending word
	task automatic hold_ready_stretches();
		int held_with_wait;
		logic [`PSX_ADDR_W-1:0] held_addr;
		logic [`PSX_DATA_W-1:0] held_data;
		held_with_wait = 0;
		for (int s = 0; s < 3; s++) begin
			@(negedge clk_1x);
			while (!ioctl_wait && !dl_finished) @(negedge clk_1x);
			if (dl_finished) break;
			@(posedge clk_1x);
			ready_hold = 1'b1;
			// a word taken on that edge leaves the next one to stall
			@(negedge clk_1x);
			while (!ioctl_wait && !dl_finished) @(negedge clk_1x);
			if (dl_finished) begin
				ready_hold = 1'b0;
				break;
			end
			held_with_wait++;
			held_addr = mem_wr_addr;
			held_data = mem_wr_data;
			repeat (12) begin
				@(negedge clk_1x);
				if (!ioctl_wait)
					report_problem("ioctl_wait dropped while ready was held low");
				if (mem_wr_valid !== 1'b1)
					report_problem("write request withdrawn while ready was held low");
				if (mem_wr_addr !== held_addr)
					report_mismatch("held address", 32'(held_addr), 32'(mem_wr_addr));
				if (mem_wr_data !== held_data)
					report_mismatch("held data", held_data, mem_wr_data);
			end
			ready_hold = 1'b0;
		end
		if (held_with_wait == 0) report_problem("no stall landed on a pending word");
	endtask

	// word k is the second half-word over the first
	task automatic check_download(input logic [31:0] base, input int nhalf);
		int key;
		logic [31:0] expv;
		for (int k = 0; k < nhalf / 2; k++) begin
			key = int'(base + 32'(4 * k));
			expv = {dl_half[2 * k + 1], dl_half[2 * k]};
			if (!log_hits.exists(key)) begin
				report_problem($sformatf("no write seen at address %h", key));
			end else begin
				if (log_hits[key] != 1) report_mismatch("download hits", 32'd1, log_hits[key]);
				if (log_data[key] !== expv) report_mismatch("download data", expv, log_data[key]);
				if (log_be[key] !== 4'hf) report_mismatch("download be", 32'hf, 32'(log_be[key]));
			end
		end
	endtask

	task automatic fill_buffer();
		logic [31:0] r;
		for (int i = 0; i < `PSX_BKBUF_DEPTH; i++) begin
			@(negedge clk_1x);
			r = $random(seed);
			buf_model[i] = r[15:0];
			sd_buff_addr = `PSX_BKBUF_AW'(i);
			sd_buff_dout = r[15:0];
			sd_buff_wr = 1'b1;
		end
		@(negedge clk_1x);
		sd_buff_wr = 1'b0;
		sd_buff_addr = '0;
		// pipelined readback with data a clock after the address
		for (int i = 0; i < `PSX_BKBUF_DEPTH; i++) begin
			@(negedge clk_1x);
			if (sd_buff_din !== buf_model[i])
				report_mismatch($sformatf("readback %0d", i), 32'(buf_model[i]), 32'(sd_buff_din));
			if (i < `PSX_BKBUF_DEPTH - 1) sd_buff_addr = `PSX_BKBUF_AW'(i + 1);
		end
	endtask

	task automatic start_flush(input int sector);
		@(negedge clk_1x);
		flush_sector = 8'(sector);
		flush_start = 1'b1;
		@(negedge clk_1x);
		flush_start = 1'b0;
		if (flush_busy !== 1'b1) report_problem("flush_busy did not rise after flush_start");
	endtask

	task automatic wait_flush_done();
		while (done_count == 0) @(negedge clk_1x);
		repeat (4) @(negedge clk_1x);
		if (done_count != 1) report_mismatch("flush_done pulses", 32'd1, done_count);
		if (flush_busy !== 1'b0) report_problem("flush_busy still high after flush_done");
	endtask

	// entry i goes to base + sector * 512 + 2i with the lane picked by address bit 1
	task automatic check_flush(input int sector);
		int key;
		logic [31:0] addr;
		logic [31:0] expv;
		logic [3:0] expbe;
		for (int i = 0; i < `PSX_BKBUF_DEPTH; i++) begin
			addr = 32'(`PSX_BACKUP_BASE) + 32'(sector) * 32'(`PSX_SECTOR_BYTES) + 32'(2 * i);
			key = int'(addr);
			expv = {buf_model[i], buf_model[i]};
			expbe = addr[1] ? 4'b1100 : 4'b0011;
			if (!log_hits.exists(key)) begin
				report_problem($sformatf("no flush write seen at address %h", key));
			end else begin
				if (log_hits[key] != 1) report_mismatch("flush hits", 32'd1, log_hits[key]);
				if (log_data[key] !== expv) report_mismatch("flush data", expv, log_data[key]);
				if (log_be[key] !== expbe) report_mismatch("flush be", 32'(expbe), 32'(log_be[key]));
			end
		end
	endtask

	// ========================================
	// one table row
	// ========================================
	task automatic run_row(input int n);
		int exp_writes;
		cur_test = row_name[n];
		test_errors = 0;
		clear_log();
		ready_hold = 1'b0;
		case (row_kind[n])
			K_RESET: begin
				if (mem_wr_valid !== 1'b0) report_problem("mem_wr_valid not low after reset");
				if (ioctl_wait !== 1'b0) report_problem("ioctl_wait not low after reset");
				if (load_exe !== 1'b0) report_problem("load_exe not low after reset");
				if (flush_busy !== 1'b0) report_problem("flush_busy not low after reset");
				if (flush_done !== 1'b0) report_problem("flush_done not low after reset");
			end
			K_BIOS, K_EXE, K_BACKP: begin
				if (row_kind[n] == K_BACKP) begin
					fork
						run_download(8'd0, row_len[n]);
						hold_ready_stretches();
					join
				end else begin
					run_download(row_kind[n] == K_EXE ? 8'd1 : 8'd0, row_len[n]);
				end
				repeat (8) @(negedge clk_1x);
				check_download(row_kind[n] == K_EXE ? 32'(`PSX_EXE_BASE) : 32'(`PSX_BIOS_BASE),
					row_len[n]);
				if (xfer_count != row_len[n] / 2)
					report_mismatch("write count", row_len[n] / 2, xfer_count);
				if (load_exe_count != (row_kind[n] == K_EXE ? 1 : 0))
					report_mismatch("load_exe pulses", (row_kind[n] == K_EXE ? 1 : 0), load_exe_count);
				if (load_exe_in_dl != 0) report_problem("load_exe pulsed during the download");
			end
			default: begin
				// flush alone or a download started while the flush runs
				fill_buffer();
				start_flush(row_sector[n]);
				exp_writes = `PSX_BKBUF_DEPTH;
				if (row_kind[n] == K_OVERLAP) begin
					repeat (10) @(negedge clk_1x);
					run_download(8'd0, row_len[n]);
					exp_writes = exp_writes + row_len[n] / 2;
				end
				wait_flush_done();
				check_flush(row_sector[n]);
				if (row_kind[n] == K_OVERLAP) check_download(32'(`PSX_BIOS_BASE), row_len[n]);
				if (xfer_count != exp_writes) report_mismatch("write count", exp_writes, xfer_count);
				if (load_exe_count != 0) report_problem("load_exe pulsed without an exe download");
			end
		endcase
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: failed with %0d errors", cur_test, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		flush_start = 1'b0;
		flush_sector = 8'd0;
		mem_wr_ready = 1'b0;
		ready_hold = 1'b0;
		dl_finished = 1'b0;
		cycle_count = 0;
		failed_tests = 0;
		total_errors = 0;
		// name, kind, half-words or entries, sector
		set_row(0, "reset_idle", K_RESET, 0, 0);
		set_row(1, "bios_download", K_BIOS, 64, 0);
		set_row(2, "exe_download", K_EXE, 48, 0);
		set_row(3, "download_backpressure", K_BACKP, 32, 0);
		set_row(4, "flush_sector5", K_FLUSH, 0, 5);
		set_row(5, "flush_download_overlap", K_OVERLAP, 40, 9);
		timeout_limit = 0;
		for (int n = 0; n < N_ROWS; n++) begin
			timeout_limit += row_len[n];
			if (row_kind[n] == K_FLUSH || row_kind[n] == K_OVERLAP)
				timeout_limit += `PSX_BKBUF_DEPTH;
		end
		timeout_limit = timeout_limit * STALL_FACTOR + 1000;
		@(posedge rst_n);
		@(negedge clk_1x);
		for (int n = 0; n < N_ROWS; n++) begin
			run_row(n);
		end
		$display("tests %0d, failed %0d, errors %0d", N_ROWS, failed_tests, total_errors);
		if (failed_tests == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* sim/tb_clock_gen.sv */
// testbench clock and reset source, 40 ns clock with reset held for three cycles
module tb_clock_gen (
	output logic clk_1x,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// half of the 40 ns period
	localparam int HALF_PERIOD = 20;

	initial begin
		clk_1x = 1'b0;
		forever #(HALF_PERIOD) clk_1x = ~clk_1x;
	end

	// release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_1x);
		@(negedge clk_1x);
		rst_n = 1'b1;
	end

endmodule

/* hw/psx_mem_loader_top.sv */
// psx memory loader top: host download and backup flush onto one write port
`include "psx_macros.svh"

module psx_mem_loader_top
	import psx_pkg::*;
(
	input logic clk_1x,
	input logic rst_n,
	// host download stream
	input logic ioctl_download,
	input logic [7:0] ioctl_index,
	input logic ioctl_wr,
	input mem_addr_t ioctl_addr,
	input logic [`PSX_HALF_W-1:0] ioctl_dout,
	output logic ioctl_wait,
	output logic load_exe,
	// host sector buffer port
	input bkbuf_addr_t sd_buff_addr,
	input logic [`PSX_HALF_W-1:0] sd_buff_dout,
	input logic sd_buff_wr,
	output logic [`PSX_HALF_W-1:0] sd_buff_din,
	// flush control
	input logic flush_start,
	input logic [7:0] flush_sector,
	output logic flush_busy,
	output logic flush_done,
	// memory write port
	output logic mem_wr_valid,
	input logic mem_wr_ready,
	output mem_addr_t mem_wr_addr,
	output mem_data_t mem_wr_data,
	output mem_be_t mem_wr_be
);

	bkbuf_addr_t fl_rd_addr;
	logic [`PSX_HALF_W-1:0] fl_rd_data;

	mem_wr_if dl_wr ();
	mem_wr_if fl_wr ();
	mem_wr_if arb_wr ();

	// ========================================
	// producers
	// ========================================
	rom_download_packer u_packer (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_wait(ioctl_wait),
		.load_exe(load_exe),
		.wr(dl_wr.producer)
	);

	// host fills it, flush engine drains it
	backup_buffer_ram u_bkbuf (
		.clk_1x(clk_1x),
		.host_addr(sd_buff_addr),
		.host_wdata(sd_buff_dout),
		.host_we(sd_buff_wr),
		.host_rdata(sd_buff_din),
		.rd_addr(fl_rd_addr),
		.rd_data(fl_rd_data)
	);

	backup_flush u_flush (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.flush_start(flush_start),
		.sector(flush_sector),
		.flush_busy(flush_busy),
		.flush_done(flush_done),
		.rd_addr(fl_rd_addr),
		.rd_data(fl_rd_data),
		.wr(fl_wr.producer)
	);

	// ========================================
	// merge
	// ========================================
	mem_write_arbiter u_arb (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.dl(dl_wr.consumer),
		.fl(fl_wr.consumer),
		.out(arb_wr.producer)
	);

	// arbiter output out to the pins
	assign mem_wr_valid = arb_wr.valid;
	assign mem_wr_addr = arb_wr.addr;
	assign mem_wr_data = arb_wr.data;
	assign mem_wr_be = arb_wr.be;
	assign arb_wr.ready = mem_wr_ready;

endmodule

/* hw/mem_write_arbiter.sv */
// memory write arbiter: shares one write port between download and flush
module mem_write_arbiter
	import psx_pkg::*;
(
	input logic clk_1x,
	input logic rst_n,
	mem_wr_if.consumer dl,
	mem_wr_if.consumer fl,
	mem_wr_if.producer out
);

	grant_e owner;
	grant_e sel;
	logic xfer;

	// ========================================
	// grant select
	// ========================================
	// held grant wins, otherwise download before flush
	always_comb begin
		if (owner != GNT_NONE) begin
			sel = owner;
		end else if (dl.valid) begin
			sel = GNT_DOWNLOAD;
		end else if (fl.valid) begin
			sel = GNT_FLUSH;
		end else begin
			sel = GNT_NONE;
		end
	end

	// ========================================
	// output mux
	// ========================================
	always_comb begin
		case (sel)
			GNT_DOWNLOAD: begin
				out.valid = dl.valid;
				out.addr = dl.addr;
				out.data = dl.data;
				out.be = dl.be;
			end
			GNT_FLUSH: begin
				out.valid = fl.valid;
				out.addr = fl.addr;
				out.data = fl.data;
				out.be = fl.be;
			end
			default: begin
				out.valid = 1'b0;
				out.addr = '0;
				out.data = '0;
				out.be = '0;
			end
		endcase
	end

	// ready only reaches the owner, the loser keeps waiting
	assign dl.ready = (sel == GNT_DOWNLOAD) & out.ready;
	assign fl.ready = (sel == GNT_FLUSH) & out.ready;

	assign xfer = out.valid & out.ready;

	// grant held until the transfer clock
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			owner <= GNT_NONE;
		end else if (xfer) begin
			owner <= GNT_NONE;
		end else begin
			owner <= sel;
		end
	end

endmodule

/* hw/backup_ram/backup_flush.sv */
// backup flush: walks the sector buffer and writes each entry to memory
`include "psx_macros.svh"

module backup_flush
	import psx_pkg::*;
(
	input logic clk_1x,
	input logic rst_n,
	input logic flush_start,
	input logic [7:0] sector,
	output logic flush_busy,
	output logic flush_done,
	output bkbuf_addr_t rd_addr,
	input logic [`PSX_HALF_W-1:0] rd_data,
	mem_wr_if.producer wr
);

	flush_state_e state;
	bkbuf_addr_t idx;
	logic [7:0] sector_q;
	logic can_start;
	logic last_entry;
	mem_addr_t entry_addr;

	// a start only counts when not already walking
	assign can_start = (state == FL_IDLE) || (state == FL_DONE);
	assign last_entry = (idx == bkbuf_addr_t'(`PSX_BKBUF_DEPTH - 1));

	// ========================================
	// walk FSM
	// ========================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			state <= FL_IDLE;
			idx <= '0;
		end else begin
			case (state)
				FL_IDLE, FL_DONE: begin
					idx <= '0;
					if (flush_start) begin
						state <= FL_READ;
					end else begin
						state <= FL_IDLE;
					end
				end
				// ram needs one clock for the entry
				FL_READ: begin
					state <= FL_REQ;
				end
				FL_REQ: begin
					if (wr.valid && wr.ready) begin
						if (last_entry) begin
							state <= FL_DONE;
						end else begin
							idx <= idx + 1'b1;
							state <= FL_READ;
						end
					end
				end
				default: begin
					state <= FL_IDLE;
				end
			endcase
		end
	end

	// sector captured with the start pulse
	always_ff @(posedge clk_1x) begin
		if (can_start && flush_start) begin
			sector_q <= sector;
		end
	end

	assign flush_busy = (state == FL_READ) || (state == FL_REQ);
	// single cycle, busy already low here
	assign flush_done = (state == FL_DONE);

	// ========================================
	// write forming
	// ========================================
	// idx held through the request so rd_data stays stable
	assign rd_addr = idx;

	// base + sector * 512 + entry * 2
	assign entry_addr = mem_addr_t'(`PSX_BACKUP_BASE)
		+ mem_addr_t'(sector_q) * mem_addr_t'(`PSX_SECTOR_BYTES)
		+ mem_addr_t'({idx, 1'b0});

	assign wr.valid = (state == FL_REQ);
	assign wr.addr = entry_addr;
	// half-word on both lanes, enables pick the live one
	assign wr.data = {rd_data, rd_data};
	assign wr.be = entry_addr[1] ? mem_be_t'(4'b1100) : mem_be_t'(4'b0011);

endmodule

/* hw/backup_ram/backup_buffer_ram.sv */
// backup buffer ram: one sector of half-words, host port and flush read port
`include "psx_macros.svh"

module backup_buffer_ram
	import psx_pkg::*;
(
	input logic clk_1x,
	input bkbuf_addr_t host_addr,
	input logic [`PSX_HALF_W-1:0] host_wdata,
	input logic host_we,
	output logic [`PSX_HALF_W-1:0] host_rdata,
	input bkbuf_addr_t rd_addr,
	output logic [`PSX_HALF_W-1:0] rd_data
);

	// ========================================
	// storage
	// ========================================
	logic [`PSX_HALF_W-1:0] mem [`PSX_BKBUF_DEPTH];

	// host side, sd sector buffer
	// read-during-write returns the new word
	always_ff @(posedge clk_1x) begin
		if (host_we) begin
			mem[host_addr] <= host_wdata;
			host_rdata <= host_wdata;
		end else begin
			host_rdata <= mem[host_addr];
		end
	end

	// flush side, read only
	// data one clock after the address
	always_ff @(posedge clk_1x) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* hw/rom_download/rom_download_packer.sv */
// rom download packer: packs host half-words into 32-bit memory writes
`include "psx_macros.svh"

module rom_download_packer
	import psx_pkg::*;
(
	input logic clk_1x,
	input logic rst_n,
	input logic ioctl_download,
	input logic [7:0] ioctl_index,
	input logic ioctl_wr,
	input mem_addr_t ioctl_addr,
	input logic [`PSX_HALF_W-1:0] ioctl_dout,
	output logic ioctl_wait,
	output logic load_exe,
	mem_wr_if.producer wr
);

	dl_target_e target_d;
	dl_target_e target;
	logic exe_q;
	logic word_pending;
	logic dl_active;
	mem_addr_t base_addr;
	mem_addr_t word_addr;
	logic [`PSX_HALF_W-1:0] lo_half;
	logic [`PSX_HALF_W-1:0] hi_half;

	// ========================================
	// download classification
	// ========================================
	// index 0 bios, 255 is codes and gets dropped
	always_comb begin
		if (!ioctl_download) begin
			target_d = DL_NONE;
		end else if (ioctl_index == 8'd0) begin
			target_d = DL_BIOS;
		end else if (ioctl_index != 8'hff) begin
			target_d = DL_EXE;
		end else begin
			target_d = DL_NONE;
		end
	end

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			target <= DL_NONE;
			exe_q <= 1'b0;
			load_exe <= 1'b0;
		end else begin
			target <= target_d;
			exe_q <= (target == DL_EXE);
			// one pulse once the exe download has gone away
			load_exe <= exe_q & (target != DL_EXE);
		end
	end

	assign dl_active = (target != DL_NONE);
	assign base_addr = (target == DL_BIOS) ? mem_addr_t'(`PSX_BIOS_BASE)
		: mem_addr_t'(`PSX_EXE_BASE);

	// ========================================
	// half-word packing
	// ========================================
	// low half carries the word address, high half completes it
	always_ff @(posedge clk_1x) begin
		if (dl_active && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				lo_half <= ioctl_dout;
				word_addr <= base_addr + ioctl_addr;
			end else begin
				hi_half <= ioctl_dout;
			end
		end
	end

	// word waits here until the arbiter takes it
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			word_pending <= 1'b0;
		end else if (wr.valid && wr.ready) begin
			word_pending <= 1'b0;
		end else if (dl_active && ioctl_wr && ioctl_addr[1]) begin
			word_pending <= 1'b1;
		end
	end

	// host held off for exactly as long as the word is outstanding
	assign ioctl_wait = word_pending;

	assign wr.valid = word_pending;
	assign wr.addr = word_addr;
	assign wr.data = {hi_half, lo_half};
	// full word always
	assign wr.be = '1;

endmodule

/* common/mem_wr_if.sv */
// mem_wr_if: valid/ready memory write channel between loader blocks
interface mem_wr_if
	import psx_pkg::*;
();
	// payload stays put from valid rise until valid & ready
	logic valid;
	logic ready;
	mem_addr_t addr;
	mem_data_t data;
	mem_be_t be;

	// source side
	modport producer (output valid, output addr, output data, output be, input ready);

	// sink side
	modport consumer (input valid, input addr, input data, input be, output ready);

endinterface

/* common/psx_pkg.sv */
// psx loader package: memory write types and the loader state encodings
`include "psx_macros.svh"

package psx_pkg;

	// ========================================
	// memory write payload
	// ========================================
	typedef logic [`PSX_ADDR_W-1:0] mem_addr_t;
	typedef logic [`PSX_DATA_W-1:0] mem_data_t;
	typedef logic [`PSX_BE_W-1:0] mem_be_t;

	// index into the backup sector buffer
	typedef logic [`PSX_BKBUF_AW-1:0] bkbuf_addr_t;

	// ========================================
	// encodings
	// ========================================
	// what the current host download is aimed at
	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE
	} dl_target_e;

	// backup flush walk, read then request per entry
	typedef enum logic [1:0] {
		FL_IDLE,
		FL_READ,
		FL_REQ,
		FL_DONE
	} flush_state_e;

	// owner of the shared memory write port
	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_DOWNLOAD,
		GNT_FLUSH
	} grant_e;

endpackage

/* common/psx_macros.svh */
// psx memory loader constants: bus widths, load bases and backup buffer size
`ifndef PSX_MACROS_SVH
`define PSX_MACROS_SVH

// ========================================
// bus widths
// ========================================
// byte address into main memory
`define PSX_ADDR_W 27
`define PSX_DATA_W 32
`define PSX_BE_W 4
// host download and backup buffer word
`define PSX_HALF_W 16

// ========================================
// memory map
// ========================================
`define PSX_BIOS_BASE 32'h0020_0000
`define PSX_EXE_BASE 32'h0040_0000
// backup region, one 512 byte sector per sector number
`define PSX_BACKUP_BASE 32'h0060_0000

// backup buffer, one sector of half-words
`define PSX_BKBUF_DEPTH 256
`define PSX_BKBUF_AW 8
`define PSX_SECTOR_BYTES 512

`endif
